// File: build.f
+incdir+include
design/sccb_pkg.sv
design/pixel_pkg.sv
design/cam_cmd_decode.sv
design/sccb_master.sv
design/pixel_capture.sv
design/cam_ctrl_top.sv
verif/cam_ctrl_tb.sv

// File: design/cam_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "cam_params.svh"

module cam_cmd_decode (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire logic          start,
  input  wire logic          cmd_credit,
  output logic               cmd_valid,
  output sccb_pkg::sccb_cmd_t cmd,
  output logic               cam_reset,
  output logic               config_done
);

  localparam int IDX_W = $clog2(`CAM_CFG_LEN);
  localparam int RST_W = $clog2(`CAM_RST_CYCLES + 1);
  localparam logic [16*`CAM_CFG_LEN-1:0] CFG_TABLE = `CAM_CFG_TABLE;

  typedef enum logic [2:0] {
    S_IDLE,
    S_HOLD,   // sensor held in reset
    S_ISSUE,
    S_DRAIN,  // wait for last write to finish
    S_DONE
  } dec_state_t;

  dec_state_t       state;
  logic [RST_W-1:0] rst_cnt;
  logic [IDX_W-1:0] idx;
  logic             credit;
  logic             issue;

  assign issue = (state == S_ISSUE) && credit && !cmd_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= S_IDLE;
      rst_cnt     <= '0;
      idx         <= '0;
      credit      <= 1'b1;
      cmd_valid   <= 1'b0;
      cam_reset   <= 1'b0;
      config_done <= 1'b0;
    end else begin
      cmd_valid <= issue;
      if (cmd_credit) credit <= 1'b1;
      else if (cmd_valid) credit <= 1'b0;  // spent on the valid cycle

      case (state)
        S_IDLE: if (start) begin
          cam_reset <= 1'b1;
          rst_cnt   <= RST_W'(`CAM_RST_CYCLES - 1);
          state     <= S_HOLD;
        end
        S_HOLD: if (rst_cnt == '0) begin
          cam_reset <= 1'b0;
          state     <= S_ISSUE;
        end else begin
          rst_cnt <= rst_cnt - 1'b1;
        end
        S_ISSUE: if (issue) begin
          idx <= idx + 1'b1;
          if (idx == IDX_W'(`CAM_CFG_LEN - 1)) state <= S_DRAIN;
        end
        S_DRAIN: if (cmd_credit) begin
          config_done <= 1'b1;
          state       <= S_DONE;
        end
        S_DONE: ;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) cmd <= CFG_TABLE[(`CAM_CFG_LEN - 1 - idx) * 16 +: 16];
  end

  a_valid_has_credit: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> credit);

  // master only returns a credit that was spent
  a_no_double_credit: assert property (@(posedge clk) disable iff (reset)
    cmd_credit |-> !credit);

endmodule

`default_nettype wire

// File: design/cam_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_ctrl_top (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              start,
  input  wire logic              fmt_yuv,
  input  wire logic              pclk,
  input  wire logic              href,
  input  wire logic              vsync,
  input  wire logic [7:0]        d,
  input  wire logic              pix_credit,
  output logic                   cam_reset,
  output logic                   config_done,
  output logic                   scl_drive_low,
  output logic                   sda_drive_low,
  output logic                   pix_valid,
  output pixel_pkg::pixel_out_t  pix,
  output logic                   pix_overflow
);

  logic                cmd_valid;
  sccb_pkg::sccb_cmd_t cmd;
  logic                cmd_credit;

  cam_cmd_decode i_decode (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .cmd_credit  (cmd_credit),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cam_reset   (cam_reset),
    .config_done (config_done)
  );

  sccb_master i_sccb (
    .clk           (clk),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .cmd_credit    (cmd_credit),
    .scl_drive_low (scl_drive_low),
    .sda_drive_low (sda_drive_low)
  );

  pixel_capture i_capture (
    .clk          (clk),
    .reset        (reset),
    .enable       (config_done),  // capture only once the sensor is set up
    .fmt_yuv      (fmt_yuv),
    .pclk         (pclk),
    .href         (href),
    .vsync        (vsync),
    .d            (d),
    .pix_credit   (pix_credit),
    .pix_valid    (pix_valid),
    .pix          (pix),
    .pix_overflow (pix_overflow)
  );

endmodule

`default_nettype wire

// File: design/pixel_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "cam_params.svh"

module pixel_capture (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              enable,
  input  wire logic              fmt_yuv,
  input  wire logic              pclk,
  input  wire logic              href,
  input  wire logic              vsync,
  input  wire logic [7:0]        d,
  input  wire logic              pix_credit,
  output logic                   pix_valid,
  output pixel_pkg::pixel_out_t  pix,
  output logic                   pix_overflow
);

  localparam int CW = $clog2(`CAM_PIX_CREDITS + 1);

  logic                  pclk_q;
  logic                  pclk_qq;
  logic                  href_q;
  logic                  href_qq;
  logic                  vsync_q;
  logic                  vsync_qq;
  logic [7:0]            d_q;
  logic                  take;
  logic                  href_fall;
  logic                  vsync_fall;
  logic                  hi_seen;
  logic                  held_valid;
  logic                  sof_pend;
  logic [7:0]            hi_byte;
  logic [7:0]            gray_new;
  pixel_pkg::pixel_word_u word;
  pixel_pkg::pixel_out_t held;  // one pixel kept back to find eol
  logic                  emit;
  logic                  emit_ok;
  logic [CW-1:0]         credits;

  always_ff @(posedge clk) begin
    if (reset) begin
      pclk_q   <= 1'b0;
      pclk_qq  <= 1'b0;
      href_q   <= 1'b0;
      href_qq  <= 1'b0;
      vsync_q  <= 1'b0;
      vsync_qq <= 1'b0;
    end else begin
      pclk_q   <= pclk;
      pclk_qq  <= pclk_q;
      href_q   <= href;
      href_qq  <= href_q;
      vsync_q  <= vsync;
      vsync_qq <= vsync_q;
    end
  end

  always_ff @(posedge clk) d_q <= d;

  assign take       = enable && pclk_q && !pclk_qq && href_q;
  assign href_fall  = enable && !href_q && href_qq;
  assign vsync_fall = enable && !vsync_q && vsync_qq;
  assign word       = {hi_byte, d_q};  // first byte is the high one
  assign emit       = held_valid && ((take && hi_seen) || href_fall);
  assign emit_ok    = emit && (credits != '0);

  always_comb begin
    if (fmt_yuv) gray_new = word.yuv.y;
    else gray_new = {word.rgb.g, word.rgb.g[5:4]};  // widen 6 to 8 bits
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hi_seen      <= 1'b0;
      held_valid   <= 1'b0;
      sof_pend     <= 1'b0;
      pix_valid    <= 1'b0;
      pix_overflow <= 1'b0;
      credits      <= CW'(`CAM_PIX_CREDITS);
    end else begin
      pix_valid <= emit_ok;
      if (emit && !emit_ok) pix_overflow <= 1'b1;  // sticky
      credits <= credits + CW'(pix_credit) - CW'(emit_ok);
      if (vsync_fall) sof_pend <= 1'b1;

      if (!enable || href_fall) begin
        hi_seen    <= 1'b0;
        held_valid <= 1'b0;
      end else if (take) begin
        hi_seen <= !hi_seen;
        if (hi_seen) begin
          held_valid <= 1'b1;
          sof_pend   <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && !hi_seen) hi_byte <= d_q;
    if (take && hi_seen) begin
      held.raw  <= word;
      held.gray <= gray_new;
      held.sof  <= sof_pend;
      held.eol  <= 1'b0;
    end
    if (emit_ok) begin
      pix     <= held;
      pix.eol <= href_fall;
    end
  end

  // consumer must not return more credits than it was granted
  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    credits <= CW'(`CAM_PIX_CREDITS));

endmodule

`default_nettype wire

// File: design/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef struct packed {
    logic [7:0] y;
    logic [7:0] chroma;  // u or v, alternating
  } yuv422_t;

  // same sensor word, read per fmt_yuv
  typedef union packed {
    rgb565_t rgb;
    yuv422_t yuv;
  } pixel_word_u;

  typedef struct packed {
    pixel_word_u raw;
    logic [7:0]  gray;
    logic        sof;
    logic        eol;
  } pixel_out_t;

endpackage

`default_nettype wire

// File: design/sccb_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "cam_params.svh"

module sccb_master (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 cmd_valid,
  input  wire sccb_pkg::sccb_cmd_t  cmd,
  output logic                      cmd_credit,
  output logic                      scl_drive_low,
  output logic                      sda_drive_low
);

  localparam int DIV_W = $clog2(`CAM_SCCB_DIV + 1);
  localparam int NBITS = sccb_pkg::SCCB_FRAME_BITS;
  localparam logic [7:0] DEV_ID = `CAM_DEV_ID;

  sccb_pkg::sccb_phase_t phase;
  logic [DIV_W-1:0]      div_cnt;
  logic [1:0]            quarter;
  logic [NBITS-1:0]      shreg;
  logic [4:0]            bit_cnt;
  logic                  qtick;
  logic                  bit_end;
  logic                  scl_nxt;
  logic                  sda_nxt;

  assign qtick   = (phase != sccb_pkg::PH_IDLE) &&
                   (div_cnt == DIV_W'(`CAM_SCCB_DIV - 1));
  assign bit_end = qtick && (quarter == 2'd3);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase      <= sccb_pkg::PH_IDLE;
      div_cnt    <= '0;
      quarter    <= '0;
      bit_cnt    <= '0;
      cmd_credit <= 1'b0;
    end else begin
      cmd_credit <= 1'b0;
      if (phase == sccb_pkg::PH_IDLE) begin
        div_cnt <= '0;
        quarter <= '0;
        if (cmd_valid) begin
          phase   <= sccb_pkg::PH_START;
          bit_cnt <= 5'(NBITS - 1);
        end
      end else if (qtick) begin
        div_cnt <= '0;
        quarter <= quarter + 1'b1;
        if (bit_end) begin
          case (phase)
            sccb_pkg::PH_START: phase <= sccb_pkg::PH_BITS;
            sccb_pkg::PH_BITS: begin
              if (bit_cnt == '0) phase <= sccb_pkg::PH_STOP;
              else bit_cnt <= bit_cnt - 1'b1;
            end
            sccb_pkg::PH_STOP: begin
              phase      <= sccb_pkg::PH_IDLE;
              cmd_credit <= 1'b1;
            end
            default: phase <= sccb_pkg::PH_IDLE;
          endcase
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // ninth bit of each frame is a 1, i.e. sda released
  always_ff @(posedge clk) begin
    if (phase == sccb_pkg::PH_IDLE && cmd_valid)
      shreg <= {DEV_ID, 1'b1, cmd.addr, 1'b1, cmd.data, 1'b1};
    else if (phase == sccb_pkg::PH_BITS && bit_end)
      shreg <= {shreg[NBITS-2:0], 1'b1};
  end

  // scl high in quarters 1 and 2, sda only moves while scl is low
  always_comb begin
    scl_nxt = 1'b0;
    sda_nxt = 1'b0;
    case (phase)
      sccb_pkg::PH_START: begin
        scl_nxt = (quarter == 2'd3);
        sda_nxt = (quarter != 2'd0);  // sda falls with scl high
      end
      sccb_pkg::PH_BITS: begin
        scl_nxt = (quarter == 2'd0) || (quarter == 2'd3);
        sda_nxt = !shreg[NBITS-1];
      end
      sccb_pkg::PH_STOP: begin
        scl_nxt = (quarter == 2'd0);
        sda_nxt = (quarter != 2'd3);  // sda rises with scl high
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      scl_drive_low <= 1'b0;
      sda_drive_low <= 1'b0;
    end else begin
      scl_drive_low <= scl_nxt;
      sda_drive_low <= sda_nxt;
    end
  end

  a_idle_released: assert property (@(posedge clk) disable iff (reset)
    (phase == sccb_pkg::PH_IDLE) |-> !scl_drive_low && !sda_drive_low);

  // decoder only issues on a credit, so never mid-transaction
  a_cmd_when_idle: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> phase == sccb_pkg::PH_IDLE);

endmodule

`default_nettype wire

// File: design/sccb_pkg.sv
`default_nettype none

package sccb_pkg;

  // one register write, device id is added by the bus master
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } sccb_cmd_t;

  // bus master phases
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_START,
    PH_BITS,
    PH_STOP
  } sccb_phase_t;

  localparam int SCCB_FRAME_BITS = 27;  // three 9-bit frames

endpackage

`default_nettype wire

// File: include/cam_params.svh
`ifndef CAM_PARAMS_SVH
`define CAM_PARAMS_SVH

`define CAM_SCCB_DIV    4      // clk cycles per quarter scl period
`define CAM_RST_CYCLES  20
`define CAM_PIX_CREDITS 4
`define CAM_DEV_ID      8'h42
`define CAM_CFG_LEN     8

// entry 0 is listed first and sits in the top bits, {addr, data} per entry
`define CAM_CFG_TABLE { \
  16'h1280, 16'h1204, 16'h1100, 16'h0C00, \
  16'h3E00, 16'h40D0, 16'h3A04, 16'h8C00  \
}

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the camera front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module cam_ctrl_tb -o cam_ctrl_sim

# the log decides the result
./obj_dir/cam_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
grep -q "Done: no errors" sim.log

// File: verif/cam_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cam_params.svh"

module cam_ctrl_tb;

  localparam int CLK_NS       = 8;
  localparam int LINE_PIX     = 6;
  localparam int BYTE_CYCLES  = 16;  // one pclk period
  localparam int TXN_CYCLES   = (sccb_pkg::SCCB_FRAME_BITS + 2) * 4 * `CAM_SCCB_DIV;
  localparam int CFG_CYCLES   = `CAM_RST_CYCLES + `CAM_CFG_LEN * (TXN_CYCLES + 8);
  localparam int FRAME_CYCLES = 8 * (2 * LINE_PIX + 8) * BYTE_CYCLES;  // all lines, with room
  localparam int WATCHDOG_NS  = (CFG_CYCLES + FRAME_CYCLES + 1000) * CLK_NS;

  logic       clk = 1'b0;
  logic       reset = 1'b1;
  logic       start = 1'b0;
  logic       fmt_yuv = 1'b0;
  logic       pclk = 1'b0;
  logic       href = 1'b0;
  logic       vsync = 1'b0;
  logic [7:0] d = 8'h00;
  logic       pix_credit = 1'b0;
  logic       cam_reset;
  logic       config_done;
  logic       scl_drive_low;
  logic       sda_drive_low;
  logic       pix_valid;
  logic       pix_overflow;
  pixel_pkg::pixel_out_t pix;

  logic [2:0]  pclk_cnt = 3'd0;
  logic        auto_credit = 1'b1;
  logic        credit_req = 1'b0;
  logic        bus_scl;
  logic        bus_sda;
  logic        prev_scl;
  logic        prev_sda;
  logic        in_txn;
  logic        bit_pend;
  logic        bit_val;
  logic [26:0] frame;
  int          nbits;
  integer      seed = 32'h2b8f_a84f;
  logic [26:0] frames[$];
  pixel_pkg::pixel_out_t got_q[$];
  pixel_pkg::pixel_out_t exp_q[$];

  cam_ctrl_top i_dut (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .fmt_yuv       (fmt_yuv),
    .pclk          (pclk),
    .href          (href),
    .vsync         (vsync),
    .d             (d),
    .pix_credit    (pix_credit),
    .cam_reset     (cam_reset),
    .config_done   (config_done),
    .scl_drive_low (scl_drive_low),
    .sda_drive_low (sda_drive_low),
    .pix_valid     (pix_valid),
    .pix           (pix),
    .pix_overflow  (pix_overflow)
  );

  always #(CLK_NS / 2) clk = !clk;

  task automatic halt_on_error();
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    halt_on_error();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
      halt_on_error();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
      halt_on_error();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
      halt_on_error();
    end
  endtask

  task automatic check_cmd(input string name, input sccb_pkg::sccb_cmd_t got,
                           input sccb_pkg::sccb_cmd_t exp);
    if (got !== exp) begin
      $display("Fail %s: got addr 0x%h data 0x%h expected addr 0x%h data 0x%h",
               name, got.addr, got.data, exp.addr, exp.data);
      halt_on_error();
    end
  endtask

  task automatic check_pix(input string name, input pixel_pkg::pixel_out_t got,
                           input pixel_pkg::pixel_out_t exp);
    if (got !== exp) begin
      $display("Fail %s: got raw 0x%h gray 0x%h sof 0x%h eol 0x%h", name,
               got.raw, got.gray, got.sof, got.eol);
      $display("Fail %s: expected raw 0x%h gray 0x%h sof 0x%h eol 0x%h", name,
               exp.raw, exp.gray, exp.sof, exp.eol);
      halt_on_error();
    end
  endtask

  function automatic pixel_pkg::pixel_out_t expect_pix(input logic [7:0] hi,
      input logic [7:0] lo, input logic yuv, input logic sof, input logic eol);
    pixel_pkg::pixel_out_t p;
    logic [5:0] g;
    g      = {hi[2:0], lo[7:5]};  // green spans the byte pair
    p.raw  = {hi, lo};
    p.gray = yuv ? hi : {g, g[5:4]};
    p.sof  = sof;
    p.eol  = eol;
    return p;
  endfunction

  // sensor pixel clock, free running
  always @(posedge clk) begin
    if (pclk_cnt == 3'd7) pclk <= !pclk;
    pclk_cnt <= pclk_cnt + 3'd1;
  end

  always @(posedge clk) pix_credit <= (auto_credit && pix_valid === 1'b1) || credit_req;

  always @(negedge clk) begin
    if (!reset && pix_valid) got_q.push_back(pix);
  end

  // open drain lines as seen on the wire
  always @(negedge clk) begin : bus_monitor
    bus_scl = !scl_drive_low;
    bus_sda = !sda_drive_low;
    if (reset) begin
      prev_scl = 1'b1;
      prev_sda = 1'b1;
      in_txn   = 1'b0;
      bit_pend = 1'b0;
    end else begin
      if (prev_scl && bus_scl && prev_sda && !bus_sda) begin
        if (in_txn) report_problem("SCCB start seen inside a transaction");
        in_txn   = 1'b1;
        bit_pend = 1'b0;
        nbits    = 0;
        frame    = '0;
      end else if (prev_scl && bus_scl && !prev_sda && bus_sda) begin
        if (!in_txn) report_problem("SCCB stop seen without a start");
        check_count("sccb bit count", nbits, sccb_pkg::SCCB_FRAME_BITS);
        check_bit("config_done at stop", config_done, 1'b0);
        frames.push_back(frame);
        in_txn   = 1'b0;
        bit_pend = 1'b0;  // scl rise of the stop carries no bit
      end else if (!prev_scl && bus_scl) begin
        if (!in_txn) report_problem("SCL pulse outside a transaction");
        bit_val  = bus_sda;
        bit_pend = 1'b1;
      end else if (prev_scl && !bus_scl && bit_pend) begin
        frame    = {frame[25:0], bit_val};  // bit done once scl falls
        nbits++;
        bit_pend = 1'b0;
      end
      prev_scl = bus_scl;
      prev_sda = bus_sda;
    end
  end

  // returns on the edge where pclk goes low
  task automatic pclk_fall();
    @(posedge clk);
    while (!(pclk && pclk_cnt == 3'd7)) @(posedge clk);
  endtask

  task automatic frame_start();
    pclk_fall();
    vsync <= 1'b1;
    repeat (2) pclk_fall();
    vsync <= 1'b0;
    pclk_fall();
  endtask

  task automatic send_line(input int n, input logic yuv, input logic sof_first);
    logic [7:0] hi;
    logic [7:0] lo;
    for (int i = 0; i < n; i++) begin
      hi = 8'($random(seed));
      lo = 8'($random(seed));
      exp_q.push_back(expect_pix(hi, lo, yuv, sof_first && i == 0, i == n - 1));
      pclk_fall();
      href <= 1'b1;
      d    <= hi;
      pclk_fall();
      d    <= lo;
    end
    pclk_fall();
    href <= 1'b0;
    d    <= 8'h00;
    repeat (2) pclk_fall();  // blanking
  endtask

  task automatic return_credits(input int n);
    repeat (n) begin
      @(posedge clk) credit_req <= 1'b1;
      @(posedge clk) credit_req <= 1'b0;
    end
  endtask

  task automatic expect_pixels();
    pixel_pkg::pixel_out_t g;
    pixel_pkg::pixel_out_t e;
    int t;
    t = 0;
    @(negedge clk);
    while (got_q.size() < exp_q.size()) begin
      @(negedge clk);
      t++;
      if (t > FRAME_CYCLES) report_problem("expected pixels did not arrive");
    end
    check_count("pixel count", got_q.size(), exp_q.size());
    while (exp_q.size() > 0) begin
      g = got_q.pop_front();
      e = exp_q.pop_front();
      check_pix("pix", g, e);
    end
  endtask

  task automatic check_idle();
    check_bit("cam_reset", cam_reset, 1'b0);
    check_bit("config_done", config_done, 1'b0);
    check_bit("scl_drive_low", scl_drive_low, 1'b0);
    check_bit("sda_drive_low", sda_drive_low, 1'b0);
    check_bit("pix_valid", pix_valid, 1'b0);
    check_bit("pix_overflow", pix_overflow, 1'b0);
  endtask

  task automatic test_reset_hold();
    int n;
    int t;
    n = 0;
    t = 0;
    @(posedge clk) start <= 1'b1;
    @(posedge clk) start <= 1'b0;
    @(negedge clk);
    while (!cam_reset) begin
      @(negedge clk);
      t++;
      if (t > 4) report_problem("cam_reset did not rise after start");
    end
    while (cam_reset) begin
      check_bit("scl_drive_low", scl_drive_low, 1'b0);
      check_bit("sda_drive_low", sda_drive_low, 1'b0);
      n++;
      @(negedge clk);
    end
    check_count("cam_reset high cycles", n, `CAM_RST_CYCLES);
  endtask

  task automatic test_config();
    logic [16*`CAM_CFG_LEN-1:0] tbl;
    logic [26:0] f;
    sccb_pkg::sccb_cmd_t want;
    int t;
    tbl = `CAM_CFG_TABLE;
    t   = 0;
    while (!config_done) begin
      @(negedge clk);
      t++;
      if (t > CFG_CYCLES) report_problem("config_done did not rise after the register table");
    end
    check_count("sccb transactions", frames.size(), `CAM_CFG_LEN);
    for (int i = 0; i < `CAM_CFG_LEN; i++) begin
      f    = frames.pop_front();
      want = tbl[16*`CAM_CFG_LEN-1 -: 16];  // next entry sits on top
      tbl  = tbl << 16;
      check_byte("sccb dev id", f[26:19], `CAM_DEV_ID);
      check_cmd("sccb cmd", {f[17:10], f[8:1]}, want);
      check_bit("sccb ninth bits", f[18] & f[9] & f[0], 1'b1);
    end
  endtask

  task automatic test_rgb();
    @(posedge clk) fmt_yuv <= 1'b0;
    frame_start();
    send_line(LINE_PIX, 1'b0, 1'b1);
    send_line(LINE_PIX, 1'b0, 1'b0);
    expect_pixels();
    check_bit("pix_overflow", pix_overflow, 1'b0);
  endtask

  task automatic test_yuv();
    @(posedge clk) fmt_yuv <= 1'b1;
    frame_start();
    send_line(LINE_PIX, 1'b1, 1'b1);
    expect_pixels();
    check_bit("pix_overflow", pix_overflow, 1'b0);
  endtask

  task automatic test_backpressure();
    pixel_pkg::pixel_out_t g;
    pixel_pkg::pixel_out_t e;
    auto_credit = 1'b0;
    @(posedge clk) fmt_yuv <= 1'b0;
    send_line(2 * `CAM_PIX_CREDITS, 1'b0, 1'b0);
    @(negedge clk);
    check_count("pixels without credit return", got_q.size(), `CAM_PIX_CREDITS);
    check_bit("pix_overflow", pix_overflow, 1'b1);
    for (int i = 0; i < `CAM_PIX_CREDITS; i++) begin
      g = got_q.pop_front();
      e = exp_q.pop_front();
      check_pix("pix", g, e);
    end
    exp_q.delete();
    return_credits(`CAM_PIX_CREDITS);
    auto_credit = 1'b1;
    send_line(3, 1'b0, 1'b0);
    expect_pixels();
    check_bit("pix_overflow", pix_overflow, 1'b1);  // sticky
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_problem("watchdog expired before the tests finished");
  end

  initial begin
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle();
    test_reset_hold();
    test_config();
    test_rgb();
    test_yuv();
    test_backpressure();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire
